/* hdl/mlp_config.svh */
`ifndef MLP_CONFIG_SVH
`define MLP_CONFIG_SVH

// Layer size
`define MLP_INPUTS 4
`define MLP_OUTPUTS 3

// Learning rate is 2**-MLP_RATE_SHIFT
`define MLP_RATE_SHIFT 2

// Fixed point fraction bits of weights and bias
`define MLP_FRACTION 8

`endif

/* hdl/mlp_pkg.sv */
`include "mlp_config.svh"

package mlp_pkg;

  // Unsigned input sample
  typedef logic [7:0] pixel_t;

  // Result, error or error term
  typedef logic signed [15:0] word_t;

  typedef pixel_t [`MLP_INPUTS-1:0] input_vector_t;
  typedef word_t [`MLP_OUTPUTS-1:0] output_vector_t;
  typedef word_t [`MLP_INPUTS-1:0] gradient_vector_t;

  // Forward, backward and update phases of one neuron
  typedef enum logic [3:0] {
    ARG,
    MUL,
    MAC,
    ACC,
    RES,
    DEL,
    ERR,
    PRP,
    UPD
  } neuron_state_t;

endpackage

/* hdl/neuron.sv */
`timescale 1ns/1ps
`include "mlp_config.svh"

module neuron #(
  parameter int N = `MLP_INPUTS,
  parameter int S = `MLP_RATE_SHIFT
) (
  input  logic clock,
  input  logic reset,
  input  logic train,

  input  logic argument_valid,
  input  mlp_pkg::pixel_t [N-1:0] argument_data,
  output logic argument_ready,

  output logic result_valid,
  output mlp_pkg::word_t result_data,
  input  logic result_ready,

  input  logic error_valid,
  input  mlp_pkg::word_t error_data,
  output logic error_ready,

  output logic propagate_valid,
  output mlp_pkg::word_t [N-1:0] propagate_data,
  input  logic propagate_ready
);
  localparam int W = `MLP_FRACTION;
  localparam int CW = (N > 1) ? $clog2(N) : 1;

  typedef logic signed [8:0] arg_t;
  typedef logic signed [17:0] ext_t;
  typedef logic signed [35:0] prod_t;
  typedef logic [CW-1:0] count_t;

  localparam count_t LAST = count_t'(N - 1);

  mlp_pkg::neuron_state_t state;
  count_t counter;
  logic stepping;

  arg_t argument [N];
  ext_t weight [N];
  ext_t bias;
  ext_t summand;
  ext_t accumulator;
  ext_t delta;

  ext_t op_a;
  ext_t op_b;
  prod_t product;

  assign argument_ready = state == mlp_pkg::ARG;
  assign error_ready = state == mlp_pkg::DEL;

  // Latch the input vector, zero extended
  always_ff @(posedge clock) begin
    if (argument_valid && argument_ready) begin
      for (int i = 0; i < N; i++) begin
        argument[i] <= arg_t'({1'b0, argument_data[i]});
      end
    end
  end

  assign stepping = state == mlp_pkg::MUL || state == mlp_pkg::MAC ||
                    state == mlp_pkg::ERR || state == mlp_pkg::UPD;

  always_ff @(posedge clock) begin
    if (reset) begin
      counter <= '0;
    end else if (stepping) begin
      counter <= (counter == LAST) ? '0 : counter + 1'b1;
    end
  end

  // One multiplier shared by all three phases
  always_comb begin
    op_a = weight[counter];
    op_b = ext_t'(argument[counter]);
    case (state)
      mlp_pkg::ERR: op_b = delta;
      mlp_pkg::UPD: op_a = delta;
      default: ;
    endcase
  end

  assign product = op_a * op_b;

  // Forward inner product
  always_ff @(posedge clock) begin
    if (state == mlp_pkg::MUL || state == mlp_pkg::MAC) begin
      summand <= ext_t'(product >>> W);
    end
  end

  always_ff @(posedge clock) begin
    if (state == mlp_pkg::ARG) begin
      accumulator <= bias;
    end else if (state == mlp_pkg::MAC || state == mlp_pkg::ACC) begin
      accumulator <= accumulator + summand;
    end
  end

  // Accumulator is stable while in RES
  assign result_data = mlp_pkg::word_t'(accumulator);

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else if (state == mlp_pkg::RES && !result_valid) begin
      result_valid <= 1'b1;
    end else if (result_valid && result_ready) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (error_valid && error_ready) begin
      delta <= ext_t'(error_data);
    end
  end

  // Error terms, one per cycle
  always_ff @(posedge clock) begin
    if (state == mlp_pkg::ERR) begin
      propagate_data[counter] <= mlp_pkg::word_t'(product >>> W);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      propagate_valid <= 1'b0;
    end else if (state == mlp_pkg::PRP && !propagate_valid) begin
      propagate_valid <= 1'b1;
    end else if (propagate_valid && propagate_ready) begin
      propagate_valid <= 1'b0;
    end
  end

  // Weight update, bias once per step
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < N; i++) begin
        weight[i] <= '0;
      end
      bias <= '0;
    end else if (state == mlp_pkg::UPD) begin
      weight[counter] <= weight[counter] + ext_t'(product >>> (S + W));
      if (counter == '0) begin
        bias <= bias + (delta >>> S);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= mlp_pkg::ARG;
    end else begin
      case (state)
        mlp_pkg::ARG: begin
          if (argument_valid) begin
            state <= mlp_pkg::MUL;
          end
        end
        mlp_pkg::MUL: begin
          state <= mlp_pkg::MAC;
        end
        mlp_pkg::MAC: begin
          if (counter == LAST) begin
            state <= mlp_pkg::ACC;
          end
        end
        mlp_pkg::ACC: begin
          state <= mlp_pkg::RES;
        end
        mlp_pkg::RES: begin
          if (result_valid && result_ready) begin
            state <= train ? mlp_pkg::DEL : mlp_pkg::ARG;
          end
        end
        mlp_pkg::DEL: begin
          if (error_valid) begin
            state <= mlp_pkg::ERR;
          end
        end
        mlp_pkg::ERR: begin
          if (counter == LAST) begin
            state <= mlp_pkg::PRP;
          end
        end
        mlp_pkg::PRP: begin
          if (propagate_valid && propagate_ready) begin
            state <= mlp_pkg::UPD;
          end
        end
        mlp_pkg::UPD: begin
          if (counter == LAST) begin
            state <= mlp_pkg::ARG;
          end
        end
        default: begin
          state <= mlp_pkg::ARG;
        end
      endcase
    end
  end

endmodule

/* hdl/layer.sv */
`timescale 1ns/1ps
`include "mlp_config.svh"

module layer (
  input  logic clock,
  input  logic reset,
  input  logic train,

  input  logic argument_valid,
  input  mlp_pkg::input_vector_t argument_data,
  output logic argument_ready,

  output logic result_valid,
  output mlp_pkg::output_vector_t result_data,
  input  logic result_ready,

  input  logic error_valid,
  input  mlp_pkg::output_vector_t error_data,
  output logic error_ready,

  output logic propagate_valid,
  output mlp_pkg::gradient_vector_t propagate_data,
  input  logic propagate_ready
);
  localparam int M = `MLP_OUTPUTS;

  logic [M-1:0] neuron_argument_ready;
  logic [M-1:0] neuron_result_valid;
  logic [M-1:0] neuron_error_ready;
  logic [M-1:0] neuron_propagate_valid;
  mlp_pkg::gradient_vector_t neuron_propagate_data [M];

  logic argument_fire;
  logic result_fire;
  logic error_fire;
  logic propagate_fire;

  // All neurons must agree before any of them moves
  assign argument_ready = &neuron_argument_ready;
  assign result_valid = &neuron_result_valid;
  assign error_ready = &neuron_error_ready;
  assign propagate_valid = &neuron_propagate_valid;

  assign argument_fire = argument_valid & argument_ready;
  assign result_fire = result_ready & result_valid;
  assign error_fire = error_valid & error_ready;
  assign propagate_fire = propagate_ready & propagate_valid;

  for (genvar j = 0; j < M; j++) begin : g_neuron
    neuron #(
      .N (`MLP_INPUTS),
      .S (`MLP_RATE_SHIFT)
    ) u_neuron (
      .clock           (clock),
      .reset           (reset),
      .train           (train),

      .argument_valid  (argument_fire),
      .argument_data   (argument_data),
      .argument_ready  (neuron_argument_ready[j]),

      .result_valid    (neuron_result_valid[j]),
      .result_data     (result_data[j]),
      .result_ready    (result_fire),

      .error_valid     (error_fire),
      .error_data      (error_data[j]),
      .error_ready     (neuron_error_ready[j]),

      .propagate_valid (neuron_propagate_valid[j]),
      .propagate_data  (neuron_propagate_data[j]),
      .propagate_ready (propagate_fire)
    );
  end

  // Sum error terms over neurons, wrapping at 16 bits
  always_comb begin
    propagate_data = '0;
    for (int j = 0; j < M; j++) begin
      for (int i = 0; i < `MLP_INPUTS; i++) begin
        propagate_data[i] = propagate_data[i] + neuron_propagate_data[j][i];
      end
    end
  end

endmodule

/* hdl/relu.sv */
`timescale 1ns/1ps
`include "mlp_config.svh"

module relu (
  input  logic clock,
  input  logic reset,

  input  logic in_valid,
  input  mlp_pkg::output_vector_t in_data,
  output logic in_ready,

  output logic out_valid,
  output mlp_pkg::output_vector_t out_data,
  input  logic out_ready,

  input  logic error_in_valid,
  input  mlp_pkg::output_vector_t error_in_data,
  output logic error_in_ready,

  output logic error_out_valid,
  output mlp_pkg::output_vector_t error_out_data,
  input  logic error_out_ready
);
  // Set for neurons whose result was not clamped
  logic [`MLP_OUTPUTS-1:0] pass;

  // Upstream result is released only when the buffer drains
  assign in_ready = out_valid & out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
      pass <= '0;
    end else if (!out_valid && in_valid) begin
      out_valid <= 1'b1;
      for (int j = 0; j < `MLP_OUTPUTS; j++) begin
        pass[j] <= !in_data[j][15];
        out_data[j] <= in_data[j][15] ? '0 : in_data[j];
      end
    end else if (out_valid && out_ready) begin
      out_valid <= 1'b0;
    end
  end

  assign error_out_valid = error_in_valid;
  assign error_in_ready = error_out_ready;

  always_comb begin
    for (int j = 0; j < `MLP_OUTPUTS; j++) begin
      error_out_data[j] = pass[j] ? error_in_data[j] : '0;
    end
  end

endmodule

/* hdl/mlp_top.sv */
`timescale 1ns/1ps

module mlp_top (
  input  logic clock,
  input  logic reset,
  input  logic train,

  input  logic argument_valid,
  input  mlp_pkg::input_vector_t argument_data,
  output logic argument_ready,

  output logic result_valid,
  output mlp_pkg::output_vector_t result_data,
  input  logic result_ready,

  input  logic error_valid,
  input  mlp_pkg::output_vector_t error_data,
  output logic error_ready,

  output logic propagate_valid,
  output mlp_pkg::gradient_vector_t propagate_data,
  input  logic propagate_ready
);
  logic layer_result_valid;
  mlp_pkg::output_vector_t layer_result_data;
  logic layer_result_ready;

  logic layer_error_valid;
  mlp_pkg::output_vector_t layer_error_data;
  logic layer_error_ready;

  layer u_layer (
    .clock           (clock),
    .reset           (reset),
    .train           (train),
    .argument_valid  (argument_valid),
    .argument_data   (argument_data),
    .argument_ready  (argument_ready),
    .result_valid    (layer_result_valid),
    .result_data     (layer_result_data),
    .result_ready    (layer_result_ready),
    .error_valid     (layer_error_valid),
    .error_data      (layer_error_data),
    .error_ready     (layer_error_ready),
    .propagate_valid (propagate_valid),
    .propagate_data  (propagate_data),
    .propagate_ready (propagate_ready)
  );

  relu u_relu (
    .clock           (clock),
    .reset           (reset),
    .in_valid        (layer_result_valid),
    .in_data         (layer_result_data),
    .in_ready        (layer_result_ready),
    .out_valid       (result_valid),
    .out_data        (result_data),
    .out_ready       (result_ready),
    .error_in_valid  (error_valid),
    .error_in_data   (error_data),
    .error_in_ready  (error_ready),
    .error_out_valid (layer_error_valid),
    .error_out_data  (layer_error_data),
    .error_out_ready (layer_error_ready)
  );

endmodule

/* test/mlp_asserts.sv */
`timescale 1ns/1ps

module mlp_asserts (
  input logic clock,
  input logic reset,
  input logic argument_ready,
  input logic result_valid,
  input mlp_pkg::output_vector_t result_data,
  input logic result_ready,
  input logic error_valid,
  input logic error_ready,
  input logic propagate_valid,
  input mlp_pkg::gradient_vector_t propagate_data,
  input logic propagate_ready
);

  // Number of failed properties so far
  int failure_count = 0;

  // Outputs hold while the consumer stalls
  result_hold: assert property (@(posedge clock) disable iff (reset)
    result_valid && !result_ready |=> result_valid && $stable(result_data))
    else begin
      failure_count++;
      $error("result channel changed under back-pressure");
    end

  propagate_hold: assert property (@(posedge clock) disable iff (reset)
    propagate_valid && !propagate_ready |=> propagate_valid && $stable(propagate_data))
    else begin
      failure_count++;
      $error("propagate channel changed under back-pressure");
    end

  error_ready_hold: assert property (@(posedge clock) disable iff (reset)
    error_ready && !error_valid |=> error_ready)
    else begin
      failure_count++;
      $error("error ready dropped before a transfer");
    end

  result_or_argument: assert property (@(posedge clock) disable iff (reset)
    !(result_valid && argument_ready))
    else begin
      failure_count++;
      $error("result valid and argument ready high together");
    end

  idle_after_reset: assert property (@(posedge clock)
    reset |=> !result_valid && !propagate_valid && !error_ready)
    else begin
      failure_count++;
      $error("handshake active right after reset");
    end

endmodule

bind mlp_top mlp_asserts u_asserts (.*);

/* test/mlp_tb.sv */
`timescale 1ns/1ps
`include "mlp_config.svh"

module mlp_tb;
  localparam int M = `MLP_OUTPUTS;
  localparam int N = `MLP_INPUTS;
  localparam int STALL_STEPS = 3;
  localparam int RANDOM_STEPS = 20;
  // Every training step and every inference counts once
  localparam int STEPS = 2 * (STALL_STEPS + RANDOM_STEPS) + 8;

  logic clock;
  logic reset;
  logic train;
  logic argument_valid;
  mlp_pkg::input_vector_t argument_data;
  logic argument_ready;
  logic result_valid;
  mlp_pkg::output_vector_t result_data;
  logic result_ready;
  logic error_valid;
  mlp_pkg::output_vector_t error_data;
  logic error_ready;
  logic propagate_valid;
  mlp_pkg::gradient_vector_t propagate_data;
  logic propagate_ready;

  integer seed = 32'h573f_3689;
  logic signed [17:0] model_weight [M][N];
  logic signed [17:0] model_bias [M];
  logic [M-1:0] model_pass;

  mlp_top u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    #(STEPS * 50 * 100);
    stop_on_error("watchdog expired before the tests completed");
  end

  task automatic stop_on_error(input string message);
    $display("%s", message);
    $display("** FAIL **");
    $fatal(1);
  endtask

  always @(negedge clock) begin
    if (u_dut.u_asserts.failure_count != 0) begin
      stop_on_error("a bound assertion on the DUT handshakes failed");
    end
  end

  task automatic check_output(input string name, input mlp_pkg::output_vector_t got,
                              input mlp_pkg::output_vector_t expected);
    if (got !== expected) begin
      stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, got, expected));
    end
  endtask

  task automatic check_gradient(input string name, input mlp_pkg::gradient_vector_t got,
                                input mlp_pkg::gradient_vector_t expected);
    if (got !== expected) begin
      stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, got, expected));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      stop_on_error($sformatf("MISMATCH %s got %h expected %h", name, got, expected));
    end
  endtask

  // Reference model of the layer
  function automatic mlp_pkg::output_vector_t model_forward(input mlp_pkg::input_vector_t a);
    logic signed [17:0] acc;
    logic signed [17:0] x;
    logic signed [35:0] p;
    mlp_pkg::output_vector_t r;
    for (int j = 0; j < M; j++) begin
      acc = model_bias[j];
      for (int i = 0; i < N; i++) begin
        x = {10'b0, a[i]};
        p = model_weight[j][i] * x;
        acc = acc + p[25:8];
      end
      r[j] = acc[15:0];
    end
    return r;
  endfunction

  function automatic mlp_pkg::output_vector_t clamp(input mlp_pkg::output_vector_t r);
    mlp_pkg::output_vector_t c;
    for (int j = 0; j < M; j++) begin
      c[j] = r[j][15] ? 16'sd0 : r[j];
    end
    return c;
  endfunction

  function automatic logic signed [17:0] gated_delta(input mlp_pkg::output_vector_t e,
                                                     input int j);
    logic signed [17:0] d;
    d = model_pass[j] ? {{2{e[j][15]}}, e[j]} : 18'sd0;
    return d;
  endfunction

  function automatic mlp_pkg::gradient_vector_t model_backward(input mlp_pkg::output_vector_t e);
    logic signed [35:0] p;
    mlp_pkg::gradient_vector_t g;
    g = '0;
    for (int j = 0; j < M; j++) begin
      for (int i = 0; i < N; i++) begin
        p = model_weight[j][i] * gated_delta(e, j);
        g[i] = g[i] + p[23:8];
      end
    end
    return g;
  endfunction

  task automatic model_update(input mlp_pkg::input_vector_t a, input mlp_pkg::output_vector_t e);
    logic signed [17:0] d;
    logic signed [17:0] x;
    logic signed [35:0] p;
    for (int j = 0; j < M; j++) begin
      d = gated_delta(e, j);
      for (int i = 0; i < N; i++) begin
        x = {10'b0, a[i]};
        p = d * x;
        model_weight[j][i] = model_weight[j][i] + p[27:10];
      end
      model_bias[j] = model_bias[j] + (d >>> `MLP_RATE_SHIFT);
    end
  endtask

  task automatic send_argument(input mlp_pkg::input_vector_t a, input logic mode);
    @(negedge clock);
    train = mode;
    argument_valid = 1'b1;
    argument_data = a;
    while (!argument_ready) @(negedge clock);
    @(negedge clock);
    argument_valid = 1'b0;
  endtask

  task automatic take_result(input mlp_pkg::output_vector_t expected, input bit stall);
    while (!result_valid) @(negedge clock);
    if (stall) repeat ($unsigned($random(seed)) % 8) @(negedge clock);
    check_output("result_data", result_data, expected);
    result_ready = 1'b1;
    @(negedge clock);
    result_ready = 1'b0;
  endtask

  task automatic send_error(input mlp_pkg::output_vector_t e);
    error_valid = 1'b1;
    error_data = e;
    while (!error_ready) @(negedge clock);
    @(negedge clock);
    error_valid = 1'b0;
  endtask

  task automatic take_propagate(input mlp_pkg::gradient_vector_t expected, input bit stall);
    while (!propagate_valid) @(negedge clock);
    if (stall) repeat ($unsigned($random(seed)) % 8) @(negedge clock);
    check_gradient("propagate_data", propagate_data, expected);
    propagate_ready = 1'b1;
    @(negedge clock);
    propagate_ready = 1'b0;
  endtask

  task automatic train_step(input mlp_pkg::input_vector_t a, input mlp_pkg::output_vector_t e,
                            input bit stall);
    mlp_pkg::output_vector_t raw;
    raw = model_forward(a);
    for (int j = 0; j < M; j++) begin
      model_pass[j] = !raw[j][15];
    end
    send_argument(a, 1'b1);
    take_result(clamp(raw), stall);
    send_error(e);
    take_propagate(model_backward(e), stall);
    model_update(a, e);
  endtask

  task automatic infer(input mlp_pkg::input_vector_t a, input bit stall);
    send_argument(a, 1'b0);
    take_result(clamp(model_forward(a)), stall);
  endtask

  function automatic mlp_pkg::output_vector_t random_error();
    mlp_pkg::output_vector_t e;
    logic [31:0] r;
    for (int j = 0; j < M; j++) begin
      r = $random(seed);
      e[j] = {{5{r[10]}}, r[10:0]};
    end
    return e;
  endfunction

  initial begin
    mlp_pkg::input_vector_t a;
    reset = 1'b1;
    train = 1'b0;
    argument_valid = 1'b0;
    argument_data = '0;
    result_ready = 1'b0;
    error_valid = 1'b0;
    error_data = '0;
    propagate_ready = 1'b0;
    for (int j = 0; j < M; j++) begin
      model_bias[j] = '0;
      for (int i = 0; i < N; i++) model_weight[j][i] = '0;
    end
    model_pass = '1;
    repeat (5) @(negedge clock);
    reset = 1'b0;

    // Idle state after reset
    @(negedge clock);
    check_bit("argument_ready", argument_ready, 1'b1);
    check_bit("result_valid", result_valid, 1'b0);
    check_bit("error_ready", error_ready, 1'b0);
    check_bit("propagate_valid", propagate_valid, 1'b0);

    // Untrained inference, no backward phase
    infer({8'd10, 8'd20, 8'd30, 8'd40}, 1'b0);
    repeat (10) begin
      @(negedge clock);
      check_bit("error_ready", error_ready, 1'b0);
      check_bit("propagate_valid", propagate_valid, 1'b0);
    end

    train_step({8'd40, 8'd80, 8'd120, 8'd160}, {16'sh0100, 16'sh0200, 16'sh0300}, 1'b0);
    infer({8'd40, 8'd80, 8'd120, 8'd160}, 1'b0);

    // Stalled consumers
    for (int k = 0; k < STALL_STEPS; k++) begin
      a = $random(seed);
      train_step(a, random_error(), 1'b1);
      infer(a, 1'b1);
    end

    // Push neuron 0 negative, then its error must vanish
    train_step({4{8'd16}}, {16'sh0000, 16'sh0000, 16'shf000}, 1'b0);
    train_step({4{8'd16}}, {16'sh0200, 16'sh0200, 16'sh0200}, 1'b0);
    if (model_pass[0]) begin
      stop_on_error("training did not drive neuron 0 to a negative result");
    end
    infer({4{8'd16}}, 1'b0);

    for (int k = 0; k < RANDOM_STEPS; k++) begin
      a = $random(seed);
      train_step(a, random_error(), 1'b0);
      infer(a, 1'b0);
    end

    if (u_dut.u_asserts.failure_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("** FAIL **");
      $fatal(1);
    end
  end

endmodule

/* project.f */
+incdir+hdl
hdl/mlp_pkg.sv
hdl/neuron.sv
hdl/layer.sv
hdl/relu.sv
hdl/mlp_top.sv
test/mlp_asserts.sv
test/mlp_tb.sv

/* Makefile */
TOP = mlp_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -F "** PASS **"

clean:
	rm -rf obj_dir
